// ==== filelist.f ====
+incdir+.
rv_pkg.sv
rv_core_if.sv
if_fetch.sv
id_decode.sv
ex_execute.sv
wb_result.sv
rv_core_top.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - files:
      - rv_pkg.sv
      - rv_core_if.sv
      - if_fetch.sv
      - id_decode.sv
      - ex_execute.sv
      - wb_result.sv
      - rv_core_top.sv
  - target: simulation
    files:
      - tb_rv_core.sv

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module tb_rv_core;

  localparam int MAX_CYCLES = 400;
  localparam logic [63:0] END_PC = `RESET_PC + 64'h60;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic [63:0] sram_rdata_i = '0;
  logic sram_data_valid_i = 1'b0;
  logic [63:0] sram_addr_o;
  logic sram_ren_o;
  logic retire_valid_o;
  logic [63:0] retire_pc_o;
  logic [4:0] retire_rd_o;
  logic retire_we_o;
  logic [63:0] retire_wdata_o;

  logic [63:0] mem [0:63];
  integer seed = 78;
  int unsigned extra;
  int unsigned wait_cnt = 0;
  logic [63:0] req_addr = '0;
  logic booted = 1'b0;
  int cycle_cnt = 0;
  logic fetch_waiting;

  // reference state and the expected outcome of the instruction at m_pc
  logic [63:0] m_rf [0:31];
  logic [63:0] m_pc, m_mtvec, m_mepc, m_a, m_b;
  logic [31:0] m_inst;
  logic [11:0] m_csr;
  logic [4:0] exp_rd;
  logic exp_we;
  logic [63:0] exp_wdata, exp_next;
  logic done;

  rv_core_top dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .sram_rdata_i      (sram_rdata_i),
    .sram_data_valid_i (sram_data_valid_i),
    .sram_addr_o       (sram_addr_o),
    .sram_ren_o        (sram_ren_o),
    .retire_valid_o    (retire_valid_o),
    .retire_pc_o       (retire_pc_o),
    .retire_rd_o       (retire_rd_o),
    .retire_we_o       (retire_we_o),
    .retire_wdata_o    (retire_wdata_o)
  );

  always #10 clk = ~clk;

  function automatic logic [5:0] word_index(input logic [63:0] addr);
    logic [63:0] off;
    off = addr - `RESET_PC;
    return off[8:3];
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] btype(input int off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'h63};
  endfunction

  function automatic logic [31:0] jtype(input int off, input logic [4:0] rd);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'h6f};
  endfunction

  // n counts instructions from the reset pc, odd n sits in the upper half
  task automatic put(input int n, input logic [31:0] inst);
    mem[n / 2][(n % 2) * 32 +: 32] = inst;
  endtask

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("ERROR %s got %h expected %h", name, got, exp);
    stop_with_failure();
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = {25'(~i), 7'h00, 25'(i), 7'h00};
    end
    put(0, itype(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
    put(1, itype(12'hffd, 5'd0, 3'd0, 5'd2, 7'h13));
    put(2, rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    put(3, rtype(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
    put(4, rtype(7'h00, 5'd2, 5'd1, 3'd7, 5'd5));
    put(5, rtype(7'h00, 5'd2, 5'd1, 3'd6, 5'd6));
    put(6, rtype(7'h00, 5'd2, 5'd1, 3'd4, 5'd7));
    put(7, {20'h12345, 5'd8, 7'h37});
    // write to x0, then read x0 back
    put(8, itype(12'd7, 5'd1, 3'd0, 5'd0, 7'h13));
    put(9, rtype(7'h00, 5'd1, 5'd0, 3'd0, 5'd9));
    put(10, btype(8, 5'd1, 5'd1, 3'd0));
    put(11, itype(12'd99, 5'd0, 3'd0, 5'd10, 7'h13));
    put(12, btype(8, 5'd1, 5'd1, 3'd1));
    put(13, btype(8, 5'd2, 5'd1, 3'd1));
    put(14, itype(12'd98, 5'd0, 3'd0, 5'd10, 7'h13));
    put(15, btype(8, 5'd2, 5'd1, 3'd0));
    put(16, jtype(8, 5'd11));
    put(17, itype(12'd97, 5'd0, 3'd0, 5'd10, 7'h13));
    put(18, {20'h80000, 5'd12, 7'h37});
    // link value plus 0x13c is the handler at 0x8000_0180
    put(19, itype(12'h13c, 5'd11, 3'd0, 5'd13, 7'h13));
    put(20, itype(12'h305, 5'd13, 3'd1, 5'd14, 7'h73));
    put(21, 32'h0000_0073);
    put(22, itype(12'd0, 5'd16, 3'd0, 5'd18, 7'h13));
    put(23, rtype(7'h00, 5'd14, 5'd18, 3'd0, 5'd19));
    put(24, jtype(0, 5'd0));
    // handler steps mepc past the ecall
    put(96, itype(12'h341, 5'd0, 3'd1, 5'd16, 7'h73));
    put(97, itype(12'd4, 5'd16, 3'd0, 5'd17, 7'h13));
    put(98, itype(12'h341, 5'd17, 3'd1, 5'd0, 7'h73));
    put(99, 32'h3020_0073);
  end

  // memory answers 1 to 3 cycles after the request
  always @(posedge clk) begin
    sram_data_valid_i <= 1'b0;
    if (sram_ren_o) begin
      booted <= 1'b1;
      extra = $unsigned($random(seed)) % 3;
      req_addr <= sram_addr_o;
      wait_cnt <= extra;
      if (extra == 0) begin
        sram_data_valid_i <= 1'b1;
        sram_rdata_i <= mem[word_index(sram_addr_o)];
      end
    end else if (wait_cnt != 0) begin
      wait_cnt <= wait_cnt - 1;
      if (wait_cnt == 1) begin
        sram_data_valid_i <= 1'b1;
        sram_rdata_i <= mem[word_index(req_addr)];
      end
    end
  end

  assign fetch_waiting = (wait_cnt != 0) || sram_data_valid_i;

  always_comb begin
    m_inst = m_pc[2] ? mem[word_index(m_pc)][63:32] : mem[word_index(m_pc)][31:0];
    m_a = m_rf[m_inst[19:15]];
    m_b = m_rf[m_inst[24:20]];
    m_csr = m_inst[31:20];
    exp_rd = m_inst[11:7];
    exp_we = 1'b0;
    exp_wdata = '0;
    exp_next = m_pc + 64'd4;
    case (m_inst[6:0])
      7'h13: begin
        exp_we = (m_inst[14:12] == 3'b000);
        exp_wdata = m_a + {{52{m_inst[31]}}, m_inst[31:20]};
      end
      7'h33: begin
        exp_we = 1'b1;
        case ({m_inst[31:25], m_inst[14:12]})
          10'h000: exp_wdata = m_a + m_b;
          10'h100: exp_wdata = m_a - m_b;
          10'h007: exp_wdata = m_a & m_b;
          10'h006: exp_wdata = m_a | m_b;
          10'h004: exp_wdata = m_a ^ m_b;
          default: exp_we = 1'b0;
        endcase
      end
      7'h37: begin
        exp_we = 1'b1;
        exp_wdata = {{32{m_inst[31]}}, m_inst[31:12], 12'h000};
      end
      7'h6f: begin
        exp_we = 1'b1;
        exp_wdata = m_pc + 64'd4;
        exp_next = m_pc + {{44{m_inst[31]}}, m_inst[19:12], m_inst[20], m_inst[30:21], 1'b0};
      end
      7'h63: begin
        if ((m_inst[14:12] == 3'd0 && m_a == m_b) || (m_inst[14:12] == 3'd1 && m_a != m_b)) begin
          exp_next = m_pc + {{52{m_inst[31]}}, m_inst[7], m_inst[30:25], m_inst[11:8], 1'b0};
        end
      end
      7'h73: begin
        if (m_inst[14:12] == 3'd1) begin
          exp_we = 1'b1;
          exp_wdata = (m_csr == 12'h305) ? m_mtvec : (m_csr == 12'h341) ? m_mepc : '0;
        end else if (m_inst[14:12] == 3'd0 && m_csr == 12'h000) begin
          exp_next = m_mtvec;
        end else if (m_inst[14:12] == 3'd0 && m_csr == 12'h302) begin
          exp_next = m_mepc;
        end
      end
      default: ;
    endcase
    if (exp_rd == 5'd0) begin
      exp_we = 1'b0;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        m_rf[i] <= '0;
      end
      m_pc <= `RESET_PC;
      m_mtvec <= `RESET_MTVEC;
      m_mepc <= '0;
      done <= 1'b0;
    end else if (retire_valid_o) begin
      if (exp_we) begin
        m_rf[exp_rd] <= exp_wdata;
      end
      if (m_inst == 32'h0000_0073) begin
        m_mepc <= m_pc;
      end else if (m_inst[6:0] == 7'h73 && m_inst[14:12] == 3'd1) begin
        if (m_csr == 12'h305) m_mtvec <= m_a;
        if (m_csr == 12'h341) m_mepc <= m_a;
      end
      m_pc <= exp_next;
      if (m_pc == END_PC) begin
        done <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  a_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
    sram_ren_o && !booted |-> sram_addr_o == `RESET_PC)
    else report_mismatch("sram_addr_o", $sampled(sram_addr_o), `RESET_PC);
  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !booted |-> !retire_valid_o)
    else report_problem("retire reported before the first fetch");
  a_retire_pc: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid_o |-> retire_pc_o == m_pc)
    else report_mismatch("retire_pc_o", $sampled(retire_pc_o), $sampled(m_pc));
  a_retire_we: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid_o |-> retire_we_o == exp_we)
    else report_mismatch("retire_we_o", $sampled(retire_we_o), $sampled(exp_we));
  a_retire_rd: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid_o && exp_we |-> retire_rd_o == exp_rd)
    else report_mismatch("retire_rd_o", $sampled(retire_rd_o), $sampled(exp_rd));
  a_retire_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid_o && exp_we |-> retire_wdata_o == exp_wdata)
    else report_mismatch("retire_wdata_o", $sampled(retire_wdata_o), $sampled(exp_wdata));
  a_fetch_on_retire: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid_o |-> sram_ren_o)
    else report_problem("no fetch issued in a retire cycle");
  a_next_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid_o |-> sram_addr_o == exp_next)
    else report_mismatch("sram_addr_o", $sampled(sram_addr_o), $sampled(exp_next));
  a_no_retire_wait: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_waiting |-> !retire_valid_o)
    else report_problem("retire reported while a fetch was outstanding");
  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_waiting |-> sram_addr_o == req_addr)
    else report_mismatch("sram_addr_o", $sampled(sram_addr_o), $sampled(req_addr));

  initial begin
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    while (!done && cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
    end
    if (done) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("timeout after %0d cycles, program did not reach its end", cycle_cnt);
      stop_with_failure();
    end
  end

endmodule

// ==== rv_core_top.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [`XLEN-1:0]  sram_rdata_i,
  input  logic              sram_data_valid_i,
  output logic [`XLEN-1:0]  sram_addr_o,
  output logic              sram_ren_o,
  output logic              retire_valid_o,
  output logic [`XLEN-1:0]  retire_pc_o,
  output logic [4:0]        retire_rd_o,
  output logic              retire_we_o,
  output logic [`XLEN-1:0]  retire_wdata_o
);

  import rv_pkg::*;

  inst_u             instr;
  logic              instr_valid;
  logic [4:0]        rs1_addr;
  logic [4:0]        rs2_addr;
  logic [`XLEN-1:0]  rs1_data;
  logic [`XLEN-1:0]  rs2_data;
  logic [`XLEN-1:0]  mtvec;
  logic [`XLEN-1:0]  mepc;
  logic [`XLEN-1:0]  pc;

  dec_bus_if  dec_bus ();
  res_bus_if  res_bus ();
  redirect_if redir ();

  // csr and pc state from the result stage feeds fetch
  assign redir.mtvec = mtvec;
  assign redir.mepc  = mepc;
  assign redir.pc    = pc;

  if_fetch u_fetch (
    .clk               (clk),
    .rst_n             (rst_n),
    .sram_rdata_i      (sram_rdata_i),
    .sram_data_valid_i (sram_data_valid_i),
    .retire_i          (res_bus.retire),
    .redir             (redir),
    .sram_addr_o       (sram_addr_o),
    .sram_ren_o        (sram_ren_o),
    .instr_o           (instr),
    .instr_valid_o     (instr_valid)
  );

  id_decode u_decode (
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .pc_i          (pc),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .dec           (dec_bus)
  );

  ex_execute u_execute (
    .instr_valid_i (instr_valid),
    .dec           (dec_bus),
    .res           (res_bus),
    .redir         (redir),
    .mtvec_i       (mtvec),
    .mepc_i        (mepc)
  );

  wb_result u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .res            (res_bus),
    .rs1_addr_i     (rs1_addr),
    .rs2_addr_i     (rs2_addr),
    .rs1_data_o     (rs1_data),
    .rs2_data_o     (rs2_data),
    .mtvec_o        (mtvec),
    .mepc_o         (mepc),
    .pc_o           (pc),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_we_o    (retire_we_o),
    .retire_wdata_o (retire_wdata_o)
  );

endmodule

// ==== wb_result.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module wb_result (
  input  logic              clk,
  input  logic              rst_n,
  res_bus_if.sink           res,
  input  logic [4:0]        rs1_addr_i,
  input  logic [4:0]        rs2_addr_i,
  output logic [`XLEN-1:0]  rs1_data_o,
  output logic [`XLEN-1:0]  rs2_data_o,
  output logic [`XLEN-1:0]  mtvec_o,
  output logic [`XLEN-1:0]  mepc_o,
  output logic [`XLEN-1:0]  pc_o,
  output logic              retire_valid_o,
  output logic [`XLEN-1:0]  retire_pc_o,
  output logic [4:0]        retire_rd_o,
  output logic              retire_we_o,
  output logic [`XLEN-1:0]  retire_wdata_o
);

  import rv_pkg::*;

  logic [`XLEN-1:0] rf_q [1:31];
  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] mtvec_q;
  logic [`XLEN-1:0] mepc_q;
  logic [1:0]       boot_q;
  logic             boot;

  // x1..x31 only
  always_ff @(posedge clk) begin
    if (res.retire && res.rd_we && res.rd != 5'd0) begin
      rf_q[res.rd] <= res.wdata;
    end
  end

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : rf_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : rf_q[rs2_addr_i];

  // pc steps onto the first fetch address as fetch issues it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_q <= 2'b00;
    end else begin
      boot_q <= {boot_q[0], 1'b1};
    end
  end

  assign boot = boot_q[0] & ~boot_q[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q    <= `RESET_PC - `XLEN'd4;
      mtvec_q <= `RESET_MTVEC;
      mepc_q  <= '0;
    end else if (boot) begin
      pc_q <= pc_q + `XLEN'd4;
    end else if (res.retire) begin
      pc_q <= res.trap_enter  ? mtvec_q :
              res.trap_return ? mepc_q  :
              res.next_pc;
      if (res.trap_enter) begin
        mepc_q <= pc_q;
      end else if (res.csr_we) begin
        case (res.csr_addr)
          CSR_MTVEC: mtvec_q <= res.csr_wdata;
          CSR_MEPC:  mepc_q  <= res.csr_wdata;
          default: ;
        endcase
      end
    end
  end

  assign pc_o    = pc_q;
  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  assign retire_valid_o = res.retire;
  assign retire_pc_o    = pc_q;
  assign retire_rd_o    = res.rd;
  assign retire_we_o    = res.retire & res.rd_we;
  assign retire_wdata_o = res.wdata;

  // decode must have dropped every x0 write
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    res.retire && res.rd_we |-> res.rd != 5'd0)
    else $error("x0 write at pc %h, wdata %h", pc_q, res.wdata);

endmodule

// ==== ex_execute.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module ex_execute (
  input  logic              instr_valid_i,
  dec_bus_if.sink           dec,
  res_bus_if.source         res,
  redirect_if.execute       redir,
  input  logic [`XLEN-1:0]  mtvec_i,
  input  logic [`XLEN-1:0]  mepc_i
);

  import rv_pkg::*;

  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] link;
  logic [`XLEN-1:0] target;
  logic [`XLEN-1:0] csr_old;
  logic             csr_hit;
  logic             is_csrrw;
  logic             taken;

  // register operand for op and branch, immediate otherwise
  assign op_b = (dec.opcode == OPC_OP || dec.opcode == OPC_BRANCH) ? dec.rs2_val : dec.imm;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_res = dec.rs1_val + op_b;
      ALU_SUB:    alu_res = dec.rs1_val - op_b;
      ALU_AND:    alu_res = dec.rs1_val & op_b;
      ALU_OR:     alu_res = dec.rs1_val | op_b;
      ALU_XOR:    alu_res = dec.rs1_val ^ op_b;
      default:    alu_res = op_b;
    endcase
  end

  // sub and xor both give zero on equal operands
  // xor marks bne
  assign taken  = (dec.opcode == OPC_BRANCH) & ((alu_res == '0) ^ (dec.alu_op == ALU_XOR));
  assign link   = dec.pc + `XLEN'd4;
  assign target = dec.pc + dec.imm;

  always_comb begin
    case (dec.csr_addr)
      CSR_MTVEC: csr_old = mtvec_i;
      CSR_MEPC:  csr_old = mepc_i;
      default:   csr_old = '0;
    endcase
  end

  assign is_csrrw = (dec.sys_op == SYS_CSRRW);
  assign csr_hit  = (dec.csr_addr == CSR_MTVEC) || (dec.csr_addr == CSR_MEPC);

  assign redir.is_jump  = instr_valid_i & ((dec.opcode == OPC_JAL) | taken);
  assign redir.pc_jump  = target;
  assign redir.in_trap  = instr_valid_i & (dec.sys_op == SYS_ECALL);
  assign redir.out_trap = instr_valid_i & (dec.sys_op == SYS_MRET);

  assign res.retire      = instr_valid_i;
  assign res.rd          = dec.rd;
  assign res.rd_we       = dec.rd_we;
  assign res.wdata       = (dec.opcode == OPC_JAL) ? link :
                           is_csrrw                ? csr_old :
                           alu_res;
  // trap targets are applied in the result stage
  assign res.next_pc     = redir.is_jump ? target : link;
  assign res.trap_enter  = redir.in_trap;
  assign res.trap_return = redir.out_trap;
  assign res.csr_we      = instr_valid_i & is_csrrw & csr_hit;
  assign res.csr_addr    = csr_addr_e'(dec.csr_addr);
  assign res.csr_wdata   = dec.rs1_val;

  // at most one redirect source per retire, trap entry and return never together
  a_redir_excl: assert #0 ($onehot0({redir.is_jump, redir.in_trap, redir.out_trap}))
    else $error("jump, trap entry and trap return overlap at pc %h", dec.pc);

endmodule

// ==== id_decode.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module id_decode (
  input  rv_pkg::inst_u     instr_i,
  input  logic              instr_valid_i,
  input  logic [`XLEN-1:0]  pc_i,
  output logic [4:0]        rs1_addr_o,
  output logic [4:0]        rs2_addr_o,
  input  logic [`XLEN-1:0]  rs1_data_i,
  input  logic [`XLEN-1:0]  rs2_data_i,
  dec_bus_if.source         dec
);

  import rv_pkg::*;

  logic we;

  assign rs1_addr_o   = instr_i.r_fmt.rs1;
  assign rs2_addr_o   = instr_i.r_fmt.rs2;
  assign dec.rs1_val  = rs1_data_i;
  assign dec.rs2_val  = rs2_data_i;
  assign dec.rd       = instr_i.r_fmt.rd;
  assign dec.csr_addr = instr_i.i_fmt.imm;
  assign dec.pc       = pc_i;

  // writes to x0 are dropped here
  assign dec.rd_we = we & instr_valid_i & (instr_i.r_fmt.rd != 5'd0);

  always_comb begin
    // unknown encodings fall through as a no-op
    dec.alu_op = ALU_ADD;
    dec.sys_op = SYS_NONE;
    dec.opcode = OPC_OP_IMM;
    dec.imm    = '0;
    we         = 1'b0;
    case (instr_i.r_fmt.opcode)
      OPC_OP: begin
        we         = 1'b1;
        dec.opcode = OPC_OP;
        case ({instr_i.r_fmt.funct7, instr_i.r_fmt.funct3})
          10'b0000000_000: dec.alu_op = ALU_ADD;
          10'b0100000_000: dec.alu_op = ALU_SUB;
          10'b0000000_111: dec.alu_op = ALU_AND;
          10'b0000000_110: dec.alu_op = ALU_OR;
          10'b0000000_100: dec.alu_op = ALU_XOR;
          default: begin
            we         = 1'b0;
            dec.opcode = OPC_OP_IMM;
          end
        endcase
      end
      OPC_OP_IMM: begin
        // only addi
        we      = (instr_i.i_fmt.funct3 == 3'b000);
        dec.imm = {{(`XLEN-12){instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
      end
      OPC_LUI: begin
        we         = 1'b1;
        dec.opcode = OPC_LUI;
        dec.alu_op = ALU_PASS_B;
        dec.imm    = {{(`XLEN-32){instr_i.u_fmt.imm[19]}}, instr_i.u_fmt.imm, 12'b0};
      end
      OPC_JAL: begin
        we         = 1'b1;
        dec.opcode = OPC_JAL;
        dec.imm    = {{(`XLEN-21){instr_i.j_fmt.imm20}}, instr_i.j_fmt.imm20,
                      instr_i.j_fmt.imm19_12, instr_i.j_fmt.imm11,
                      instr_i.j_fmt.imm10_1, 1'b0};
      end
      OPC_BRANCH: begin
        dec.imm = {{(`XLEN-13){instr_i.b_fmt.imm12}}, instr_i.b_fmt.imm12,
                   instr_i.b_fmt.imm11, instr_i.b_fmt.imm10_5,
                   instr_i.b_fmt.imm4_1, 1'b0};
        // beq compares with sub, bne with xor
        if (instr_i.b_fmt.funct3 == 3'b000) begin
          dec.opcode = OPC_BRANCH;
          dec.alu_op = ALU_SUB;
        end else if (instr_i.b_fmt.funct3 == 3'b001) begin
          dec.opcode = OPC_BRANCH;
          dec.alu_op = ALU_XOR;
        end
      end
      OPC_SYSTEM: begin
        dec.opcode = OPC_SYSTEM;
        if (instr_i.i_fmt.funct3 == 3'b001) begin
          we         = 1'b1;
          dec.sys_op = SYS_CSRRW;
        end else if (instr_i.i_fmt.funct3 == 3'b000) begin
          if (instr_i.i_fmt.imm == 12'h000) begin
            dec.sys_op = SYS_ECALL;
          end else if (instr_i.i_fmt.imm == 12'h302) begin
            dec.sys_op = SYS_MRET;
          end
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== if_fetch.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module if_fetch (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [`XLEN-1:0]  sram_rdata_i,
  input  logic              sram_data_valid_i,
  input  logic              retire_i,
  redirect_if.consumer      redir,
  output logic [`XLEN-1:0]  sram_addr_o,
  output logic              sram_ren_o,
  output rv_pkg::inst_u     instr_o,
  output logic              instr_valid_o
);

  logic [1:0]        boot_q;
  logic              boot;
  logic              pending_q;
  logic              accept;
  logic [`XLEN-1:0]  addr_q;
  logic [`XLEN-1:0]  pc_next;

  // boot_q[0] sets on the first edge out of reset, boot_q[1] one edge later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_q <= 2'b00;
    end else begin
      boot_q <= {boot_q[0], 1'b1};
    end
  end

  assign boot = boot_q[0] & ~boot_q[1];

  // jump first, then trap entry, then trap return, else sequential
  assign pc_next = redir.is_jump  ? redir.pc_jump :
                   redir.in_trap  ? redir.mtvec   :
                   redir.out_trap ? redir.mepc    :
                   redir.pc + `XLEN'd4;

  assign sram_ren_o  = boot | retire_i;
  // address held from the request until the data returns
  assign sram_addr_o = sram_ren_o ? pc_next : addr_q;
  assign accept      = sram_data_valid_i & pending_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q     <= 1'b0;
      addr_q        <= '0;
      instr_valid_o <= 1'b0;
    end else begin
      instr_valid_o <= accept;
      if (sram_ren_o) begin
        pending_q <= 1'b1;
        addr_q    <= pc_next;
      end else if (accept) begin
        pending_q <= 1'b0;
      end
    end
  end

  // bit 2 picks the upper or lower instruction in the word
  always_ff @(posedge clk) begin
    if (accept) begin
      instr_o <= addr_q[2] ? sram_rdata_i[`XLEN-1:`INST_LEN]
                           : sram_rdata_i[`INST_LEN-1:0];
    end
  end

  // one request at a time
  a_single_req: assert property (@(posedge clk) disable iff (!rst_n)
    sram_ren_o |-> !pending_q)
    else $error("sram_ren_o raised while a fetch is outstanding, addr %h", addr_q);

endmodule

// ==== rv_core_if.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

// decoded instruction, decode to execute
interface dec_bus_if;
  import rv_pkg::*;

  alu_op_e            alu_op;
  sys_op_e            sys_op;
  opcode_e            opcode;
  logic [`XLEN-1:0]   rs1_val;
  logic [`XLEN-1:0]   rs2_val;
  logic [`XLEN-1:0]   imm;
  logic [4:0]         rd;
  logic               rd_we;
  logic [11:0]        csr_addr;
  logic [`XLEN-1:0]   pc;

  modport source (
    output alu_op, sys_op, opcode, rs1_val, rs2_val, imm, rd, rd_we, csr_addr, pc
  );
  modport sink (
    input alu_op, sys_op, opcode, rs1_val, rs2_val, imm, rd, rd_we, csr_addr, pc
  );
endinterface

// execute results, execute to result stage
interface res_bus_if;
  import rv_pkg::*;

  logic               retire;
  logic [4:0]         rd;
  logic               rd_we;
  logic [`XLEN-1:0]   wdata;
  logic [`XLEN-1:0]   next_pc;
  logic               trap_enter;
  logic               trap_return;
  logic               csr_we;
  csr_addr_e          csr_addr;
  logic [`XLEN-1:0]   csr_wdata;

  modport source (
    output retire, rd, rd_we, wdata, next_pc, trap_enter, trap_return,
    output csr_we, csr_addr, csr_wdata
  );
  modport sink (
    input retire, rd, rd_we, wdata, next_pc, trap_enter, trap_return,
    input csr_we, csr_addr, csr_wdata
  );
endinterface

// next-pc sources seen by fetch
interface redirect_if;
  logic               is_jump;
  logic [`XLEN-1:0]   pc_jump;
  logic               in_trap;
  logic               out_trap;
  logic [`XLEN-1:0]   mtvec;
  logic [`XLEN-1:0]   mepc;
  logic [`XLEN-1:0]   pc;

  modport execute (output is_jump, pc_jump, in_trap, out_trap);
  modport consumer (input is_jump, pc_jump, in_trap, out_trap, mtvec, mepc, pc);
endinterface

// ==== rv_pkg.sv ====
package rv_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    SYS_NONE,
    SYS_ECALL,
    SYS_MRET,
    SYS_CSRRW
  } sys_op_e;

  typedef enum logic [11:0] {
    CSR_MTVEC = 12'h305,
    CSR_MEPC  = 12'h341
  } csr_addr_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, seen through each encoding format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } inst_u;

endpackage

// ==== rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data and address width
`define XLEN 64

// one instruction, half of a memory word
`define INST_LEN 32

// first fetch address
// the pc register resets 4 below this, so pc + 4 lands here
`define RESET_PC 64'h0000_0000_8000_0000

// trap vector after reset
`define RESET_MTVEC 64'h0000_0000_8000_0100

`endif
